// File: hw/rv32_pkg.sv
package rv32_pkg;

    // Data RAM geometry with the word index taken from byte address bits 9:2
    localparam int DATA_RAM_WORDS     = 256;
    localparam int DATA_RAM_ADDR_BITS = 8;

    typedef enum logic [1:0] {
        MEM_WIDTH_WORD = 2'b00,
        MEM_WIDTH_HALF = 2'b01,
        MEM_WIDTH_BYTE = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        BRANCH_NONE = 2'b00,
        BRANCH_EQ   = 2'b01,
        BRANCH_NE   = 2'b10,
        BRANCH_JUMP = 2'b11
    } branch_op_e;

    // One instruction handed from execute to memory
    typedef struct packed {
        logic        valid;
        logic        branch_predicted_taken;
        logic        alu_non_zero;
        logic        read;
        logic        write;
        mem_width_e  width;
        logic        zero_extend;
        branch_op_e  branch_op;
        logic [4:0]  rd;
        logic        rd_write;
        logic [31:0] result;
        logic [31:0] rs2_value;
        logic [31:0] branch_pc;
    } ex_mem_t;

    // Data bus request toward the RAM
    typedef struct packed {
        logic        read;
        logic        write;
        logic [3:0]  write_mask;
        logic [31:0] address;
        logic [31:0] write_value;
    } dmem_req_t;

    // Retiring instruction toward the register file
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        rd_write;
        logic [31:0] rd_value;
    } mem_wb_t;

endpackage

// File: hw/rv32_ex_mem_reg.sv
`timescale 1ns/10ps

module rv32_ex_mem_reg
    import rv32_pkg::*;
(
    input  logic    clk,
    input  logic    reset_,
    input  logic    stall,
    input  ex_mem_t ex,
    output ex_mem_t ex_mem
);

    ex_mem_t ex_clean;

    // A bubble must never touch memory, registers or the branch logic
    always_comb begin
        ex_clean = ex;
        if (!ex.valid) begin
            ex_clean.read                   = 1'b0;
            ex_clean.write                  = 1'b0;
            ex_clean.rd_write               = 1'b0;
            ex_clean.branch_op              = BRANCH_NONE;
            ex_clean.branch_predicted_taken = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            ex_mem.valid                  <= 1'b0;
            ex_mem.read                   <= 1'b0;
            ex_mem.write                  <= 1'b0;
            ex_mem.rd_write               <= 1'b0;
            ex_mem.branch_op              <= BRANCH_NONE;
            ex_mem.branch_predicted_taken <= 1'b0;
        end else if (!stall) begin
            ex_mem <= ex_clean;
        end
    end

endmodule

// File: hw/rv32_branch_unit.sv
`timescale 1ns/10ps

module rv32_branch_unit
    import rv32_pkg::*;
(
    input  logic       predicted_taken,
    input  logic       alu_non_zero,
    input  branch_op_e op,
    output logic       mispredicted
);

    logic taken;

    // Actual outcome with EQ and NE taken from the ALU zero flag
    always_comb begin
        case (op)
            BRANCH_NONE: taken = 1'b0;
            BRANCH_EQ:   taken = !alu_non_zero;
            BRANCH_NE:   taken = alu_non_zero;
            BRANCH_JUMP: taken = 1'b1;
            default:     taken = 1'b0;
        endcase
    end

    assign mispredicted = taken != predicted_taken;

endmodule

// File: hw/rv32_mem.sv
`timescale 1ns/10ps

module rv32_mem
    import rv32_pkg::*;
(
    input  logic        clk,
    input  logic        reset_,
    input  logic        stall,
    input  logic        flush,
    input  ex_mem_t     ex_mem,
    input  logic [31:0] read_value,
    output dmem_req_t   dmem_req,
    output logic        branch_mispredicted,
    output logic [31:0] branch_pc,
    output mem_wb_t     wb
);

    logic [1:0]  byte_sel;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic        load_sign;
    logic [31:0] load_value;
    logic [31:0] store_value;
    logic [3:0]  store_mask;

    rv32_branch_unit branch_unit (
        .predicted_taken (ex_mem.branch_predicted_taken),
        .alu_non_zero    (ex_mem.alu_non_zero),
        .op              (ex_mem.branch_op),
        .mispredicted    (branch_mispredicted)
    );

    assign branch_pc = ex_mem.branch_pc;
    assign byte_sel  = ex_mem.result[1:0];

    // Store lane steering with unused lanes driven as zero
    always_comb begin
        store_value = 32'h0;
        store_mask  = 4'b0000;
        if (ex_mem.write) begin
            case (ex_mem.width)
                MEM_WIDTH_WORD: begin
                    store_value = ex_mem.rs2_value;
                    store_mask  = 4'b1111;
                end
                MEM_WIDTH_HALF: begin
                    if (byte_sel[1]) begin
                        store_value = {ex_mem.rs2_value[15:0], 16'h0};
                        store_mask  = 4'b1100;
                    end else begin
                        store_value = {16'h0, ex_mem.rs2_value[15:0]};
                        store_mask  = 4'b0011;
                    end
                end
                MEM_WIDTH_BYTE: begin
                    store_value = {24'h0, ex_mem.rs2_value[7:0]} << (8 * byte_sel);
                    store_mask  = 4'b0001 << byte_sel;
                end
                default: begin
                    store_value = 32'h0;
                    store_mask  = 4'b0000;
                end
            endcase
        end
    end

    always_comb begin
        dmem_req.read        = ex_mem.read;
        dmem_req.write       = ex_mem.write;
        dmem_req.write_mask  = store_mask;
        dmem_req.address     = ex_mem.result;
        dmem_req.write_value = store_value;
    end

    // Load extraction with the halfword picked by address bit 1
    always_comb begin
        load_byte = read_value[8 * byte_sel +: 8];
        load_half = byte_sel[1] ? read_value[31:16] : read_value[15:0];
        load_sign = 1'b0;
        case (ex_mem.width)
            MEM_WIDTH_HALF: begin
                load_sign  = !ex_mem.zero_extend && load_half[15];
                load_value = {{16{load_sign}}, load_half};
            end
            MEM_WIDTH_BYTE: begin
                load_sign  = !ex_mem.zero_extend && load_byte[7];
                load_value = {{24{load_sign}}, load_byte};
            end
            default: load_value = read_value;
        endcase
    end

    // Memory/writeback register
    always_ff @(posedge clk) begin
        if (!reset_) begin
            wb <= '0;
        end else if (!stall) begin
            wb.valid    <= ex_mem.valid && !flush;
            wb.rd       <= ex_mem.rd;
            wb.rd_write <= ex_mem.rd_write && !flush;
            wb.rd_value <= ex_mem.read ? load_value : ex_mem.result;
        end
    end

endmodule

// File: hw/rv32_data_ram.sv
`timescale 1ns/10ps

module rv32_data_ram
    import rv32_pkg::*;
(
    input  logic        clk,
    input  dmem_req_t   dmem_req,
    output logic [31:0] read_value
);

    logic [31:0] mem [DATA_RAM_WORDS];
    logic [DATA_RAM_ADDR_BITS-1:0] word_index;

    // Upper address bits fold onto the same words
    assign word_index = dmem_req.address[DATA_RAM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (dmem_req.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dmem_req.write_mask[lane]) begin
                    mem[word_index][8*lane +: 8] <= dmem_req.write_value[8*lane +: 8];
                end
            end
        end
    end

    assign read_value = dmem_req.read ? mem[word_index] : 32'h0;

endmodule

// File: hw/rv32_regfile.sv
`timescale 1ns/10ps

module rv32_regfile
    import rv32_pkg::*;
(
    input  logic        clk,
    input  logic        reset_,
    input  mem_wb_t     wb,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value
);

    logic [31:0] regs [32];
    logic        write_en;

    assign write_en = wb.valid && wb.rd_write && (wb.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (!reset_) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (write_en) begin
            regs[wb.rd] <= wb.rd_value;
        end
    end

    // x0 reads as zero
    assign rs1_value = (rs1_addr == 5'd0) ? 32'h0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == 5'd0) ? 32'h0 : regs[rs2_addr];

endmodule

// File: hw/rv32_mem_subsys.sv
`timescale 1ns/10ps

module rv32_mem_subsys
    import rv32_pkg::*;
(
    input  logic        clk,
    input  logic        reset_,
    input  logic        stall,
    input  logic        flush,
    input  ex_mem_t     ex,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic        branch_mispredicted,
    output logic [31:0] branch_pc,
    output mem_wb_t     wb,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value
);

    ex_mem_t     ex_mem;
    dmem_req_t   dmem_req;
    logic [31:0] read_value;

    rv32_ex_mem_reg ex_mem_reg (
        .clk    (clk),
        .reset_ (reset_),
        .stall  (stall),
        .ex     (ex),
        .ex_mem (ex_mem)
    );

    rv32_mem mem_stage (
        .clk                 (clk),
        .reset_              (reset_),
        .stall               (stall),
        .flush               (flush),
        .ex_mem              (ex_mem),
        .read_value          (read_value),
        .dmem_req            (dmem_req),
        .branch_mispredicted (branch_mispredicted),
        .branch_pc           (branch_pc),
        .wb                  (wb)
    );

    rv32_data_ram data_ram (
        .clk        (clk),
        .dmem_req   (dmem_req),
        .read_value (read_value)
    );

    rv32_regfile regfile (
        .clk       (clk),
        .reset_    (reset_),
        .wb        (wb),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

endmodule

// File: tests/rv32_mem_checker.sv
`timescale 1ns/10ps

module rv32_mem_checker
    import rv32_pkg::*;
(
    input logic      clk,
    input logic      reset_,
    input logic      stall,
    input logic      flush,
    input dmem_req_t dmem_req,
    input mem_wb_t   wb
);

    // No byte lane may be enabled on a cycle without a store
    mask_needs_write: assert property (
        @(posedge clk) disable iff (!reset_) !dmem_req.write |-> dmem_req.write_mask == 4'b0000
    ) else $error("write_mask %h active without a write", dmem_req.write_mask);

    rd_write_needs_valid: assert property (
        @(posedge clk) disable iff (!reset_) wb.rd_write |-> wb.valid
    ) else $error("wb.rd_write set on an invalid writeback");

    wb_clear_after_reset: assert property (
        @(posedge clk) !reset_ |=> !wb.valid
    ) else $error("wb.valid set in the cycle after reset");

    // Flush only counts when the pipeline moves
    flush_kills_wb: assert property (
        @(posedge clk) disable iff (!reset_) flush && !stall |=> !wb.valid
    ) else $error("wb.valid survived a flush");

endmodule

// File: tests/rv32_mem_subsys_tb.sv
`timescale 1ns/10ps

module rv32_mem_subsys_tb
    import rv32_pkg::*;
();

    localparam int WORD_PAIRS   = 40;
    localparam int NARROW_PAIRS = 60;
    localparam int SINGLE_OPS   = 60;
    localparam int TOTAL_CYCLES = 8 + 16 + 2 * WORD_PAIRS + 2 * NARROW_PAIRS
                                + 6 * SINGLE_OPS + 10;

    typedef enum {ALU_OP, BRANCH_OP, STORE_OP, LOAD_OP} op_kind_e;

    logic        clk;
    logic        reset_;
    logic        stall;
    logic        flush;
    ex_mem_t     ex;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic        branch_mispredicted;
    logic [31:0] branch_pc;
    mem_wb_t     wb;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;

    logic [31:0] lfsr;
    logic [7:0]  ram_bytes [1024];
    logic [31:0] regs [32];
    ex_mem_t     inflight [$];
    int          checks;
    int          errors;
    int          base_checks;
    int          base_errors;

    rv32_mem_subsys uut (.*);

    bind rv32_mem rv32_mem_checker mem_checker (
        .clk      (clk),
        .reset_   (reset_),
        .stall    (stall),
        .flush    (flush),
        .dmem_req (dmem_req),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(20 * (TOTAL_CYCLES + 50));
        $display("Timeout: the tests did not finish before the watchdog expired");
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, expected);
        end
    endtask

    function automatic logic [31:0] aligned_addr(input mem_width_e width, input logic [31:0] base);
        logic [31:0] r;
        r = lfsr_bits(2);
        case (width)
            MEM_WIDTH_HALF: return {base[31:2], r[0], 1'b0};
            MEM_WIDTH_BYTE: return {base[31:2], r[1:0]};
            default:        return {base[31:2], 2'b00};
        endcase
    endfunction

    function automatic ex_mem_t random_ins(input op_kind_e kind, input logic word_only);
        ex_mem_t     ins;
        logic [31:0] r;
        logic [31:0] idx;
        ins = '0;
        ins.valid = 1'b1;
        r = lfsr_bits(12);
        idx = lfsr_bits(4);
        ins.rd = r[4:0];
        ins.zero_extend = r[5];
        ins.width = (word_only || r[7:6] == 2'b11) ? MEM_WIDTH_WORD : mem_width_e'(r[7:6]);
        ins.rd_write = kind == ALU_OP || kind == LOAD_OP || (kind == BRANCH_OP && r[8]);
        ins.read = kind == LOAD_OP;
        ins.write = kind == STORE_OP;
        ins.rs2_value = lfsr_bits(32);
        ins.result = lfsr_bits(32);
        ins.branch_pc = lfsr_bits(32);
        if (kind == BRANCH_OP) begin
            ins.branch_op = branch_op_e'(r[10:9]);
            ins.branch_predicted_taken = r[11];
            ins.alu_non_zero = ins.result[0];
        end
        // Loads and stores stay inside the first 16 words
        if (ins.read || ins.write) begin
            ins.result = aligned_addr(ins.width, {26'h0, idx[3:0], 2'b00});
        end
        return ins;
    endfunction

    function automatic logic [31:0] model_load(input ex_mem_t ins);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = ins.result[9:0];
        b = ram_bytes[a];
        h = {ram_bytes[a + 10'd1], ram_bytes[a]};
        case (ins.width)
            MEM_WIDTH_BYTE: return ins.zero_extend ? {24'h0, b} : {{24{b[7]}}, b};
            MEM_WIDTH_HALF: return ins.zero_extend ? {16'h0, h} : {{16{h[15]}}, h};
            default: return {ram_bytes[a + 10'd3], ram_bytes[a + 10'd2], h};
        endcase
    endfunction

    task automatic model_store(input ex_mem_t ins);
        logic [9:0] a;
        a = ins.result[9:0];
        ram_bytes[a] = ins.rs2_value[7:0];
        if (ins.width != MEM_WIDTH_BYTE) begin
            ram_bytes[a + 10'd1] = ins.rs2_value[15:8];
        end
        if (ins.width == MEM_WIDTH_WORD) begin
            ram_bytes[a + 10'd2] = ins.rs2_value[23:16];
            ram_bytes[a + 10'd3] = ins.rs2_value[31:24];
        end
    endtask

    function automatic logic branch_taken(input ex_mem_t ins);
        case (ins.branch_op)
            BRANCH_EQ:   return !ins.alu_non_zero;
            BRANCH_NE:   return ins.alu_non_zero;
            BRANCH_JUMP: return 1'b1;
            default:     return 1'b0;
        endcase
    endfunction

    // One pipeline advance where ins enters and the oldest instruction retires
    task automatic step(input ex_mem_t ins, input logic flush_in);
        ex_mem_t     done;
        mem_wb_t     expected;
        logic [31:0] r;
        r = lfsr_bits(5);
        ex = ins;
        stall = 1'b0;
        flush = flush_in;
        rs2_addr = r[4:0];
        @(negedge clk);
        check_value("rs1_value", 64'(rs1_value), 64'(regs[rs1_addr]));
        check_value("rs2_value", 64'(rs2_value), 64'(regs[rs2_addr]));
        done = inflight.pop_front();
        expected.valid = done.valid && !flush_in;
        expected.rd = done.rd;
        expected.rd_write = done.rd_write && !flush_in;
        expected.rd_value = done.read ? model_load(done) : done.result;
        if (done.valid && done.write) begin
            model_store(done);
        end
        if (done.valid) begin
            check_value("wb", 64'(wb), 64'(expected));
        end else begin
            check_value("wb.valid", 64'(wb.valid), 64'(0));
        end
        if (expected.valid && expected.rd_write && expected.rd != 5'd0) begin
            regs[expected.rd] = expected.rd_value;
        end
        rs1_addr = expected.rd;
        inflight.push_back(ins);
        check_value("branch_mispredicted", 64'(branch_mispredicted),
                    64'(ins.valid && (branch_taken(ins) != ins.branch_predicted_taken)));
        check_value("branch_pc", 64'(branch_pc), 64'(ins.branch_pc));
    endtask

    task automatic stall_cycle(input ex_mem_t ins);
        mem_wb_t     held;
        logic [31:0] r;
        held = wb;
        r = lfsr_bits(1);
        ex = ins;
        stall = 1'b1;
        flush = r[0];
        @(negedge clk);
        check_value("wb", 64'(wb), 64'(held));
    endtask

    // Bubbles carry random control bits that must all be ignored
    task automatic drain();
        ex_mem_t     bubble;
        logic [31:0] r;
        for (int i = 0; i < 2; i++) begin
            r = lfsr_bits(2);
            bubble = random_ins(op_kind_e'(r[1:0]), 1'b0);
            bubble.valid = 1'b0;
            step(bubble, 1'b0);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - base_checks, errors - base_errors);
        base_checks = checks;
        base_errors = errors;
    endtask

    initial begin
        ex_mem_t     st;
        ex_mem_t     ld;
        logic [31:0] r;
        lfsr = 32'h8440;
        reset_ = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        ex = '0;
        rs1_addr = 5'd0;
        rs2_addr = 5'd0;
        checks = 0;
        errors = 0;
        base_checks = 0;
        base_errors = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        inflight.push_back('0);
        repeat (8) @(negedge clk);
        reset_ = 1'b1;

        // Fill the 16-word window so every later load sees known data
        for (int i = 0; i < 16; i++) begin
            st = random_ins(STORE_OP, 1'b1);
            st.result = {26'h0, i[3:0], 2'b00};
            step(st, 1'b0);
        end
        for (int i = 0; i < WORD_PAIRS; i++) begin
            st = random_ins(STORE_OP, 1'b1);
            ld = random_ins(LOAD_OP, 1'b1);
            ld.result = st.result;
            step(st, 1'b0);
            step(ld, 1'b0);
        end
        drain();
        report_test("word store and load");

        for (int i = 0; i < NARROW_PAIRS; i++) begin
            st = random_ins(STORE_OP, 1'b0);
            ld = random_ins(LOAD_OP, 1'b0);
            ld.result = aligned_addr(ld.width, st.result);
            step(st, 1'b0);
            step(ld, 1'b0);
        end
        drain();
        report_test("byte and halfword access");

        for (int i = 0; i < SINGLE_OPS; i++) begin
            st = random_ins(ALU_OP, 1'b0);
            if (i % 8 == 0) begin
                st.rd = 5'd0;
            end
            step(st, 1'b0);
        end
        drain();
        report_test("writeback and register file");

        for (int i = 0; i < SINGLE_OPS; i++) begin
            step(random_ins(BRANCH_OP, 1'b0), 1'b0);
        end
        drain();
        report_test("branch misprediction");

        for (int i = 0; i < SINGLE_OPS; i++) begin
            r = lfsr_bits(6);
            step(random_ins(op_kind_e'(r[5:4]), 1'b0), r[0] && r[1]);
            repeat (r[3:2]) stall_cycle(random_ins(ALU_OP, 1'b0));
        end
        drain();
        report_test("stall and flush");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: project.f
hw/rv32_pkg.sv
hw/rv32_ex_mem_reg.sv
hw/rv32_branch_unit.sv
hw/rv32_mem.sv
hw/rv32_data_ram.sv
hw/rv32_regfile.sv
hw/rv32_mem_subsys.sv
tests/rv32_mem_checker.sv
tests/rv32_mem_subsys_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f project.f \
    --top-module rv32_mem_subsys_tb -o sim \
    && ./obj_dir/sim | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
